/* list.f */
+incdir+verilog
verilog/bitmanip_pkg.sv
verilog/bitmanip_decoder.sv
verilog/bitmanip_logic_unit.sv
verilog/bitmanip_shift_unit.sv
verilog/bitmanip_count_unit.sv
verilog/bitmanip_core.sv
tests/bitmanip_checker.sv
tests/bitmanip_tb.sv

/* Makefile */
# Verilator build and run of the bit-manipulation core testbench.
# make compile builds, make run simulates and checks the log, make clean tidies.

VERILATOR ?= verilator
TOP       ?= bitmanip_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/bitmanip_tb.sv */
// Testbench top of the bit-manipulation core.
// Drives random supported and unsupported instructions with random output
// back-pressure; the checker module predicts and compares every result.
`timescale 1ns/1ps
`include "bitmanip_config.svh"

module bitmanip_tb;

	localparam int NUM_INSNS      = 1500;
	localparam int TIMEOUT_CYCLES = NUM_INSNS * 20;

	logic        clock;
	logic        reset;
	logic        din_valid;
	logic        din_ready;
	logic        din_decoded;
	logic [31:0] din_rs1;
	logic [31:0] din_rs2;
	logic [31:0] din_insn;
	logic        dout_valid;
	logic        dout_ready;
	logic [31:0] dout_rd;
	int          value_errors;
	int          other_errors;
	int          pending;
	int          cycles;

	bitmanip_core i_bitmanip_core (
		.clock       (clock),
		.reset       (reset),
		.din_valid   (din_valid),
		.din_ready   (din_ready),
		.din_decoded (din_decoded),
		.din_rs1     (din_rs1),
		.din_rs2     (din_rs2),
		.din_insn    (din_insn),
		.dout_valid  (dout_valid),
		.dout_ready  (dout_ready),
		.dout_rd     (dout_rd)
	);

	bitmanip_checker result_checker (
		.clock        (clock),
		.reset        (reset),
		.din_valid    (din_valid),
		.din_ready    (din_ready),
		.din_decoded  (din_decoded),
		.din_rs1      (din_rs1),
		.din_rs2      (din_rs2),
		.din_insn     (din_insn),
		.dout_valid   (dout_valid),
		.dout_ready   (dout_ready),
		.dout_rd      (dout_rd),
		.value_errors (value_errors),
		.other_errors (other_errors),
		.pending      (pending)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic next_cycle();
		@(posedge clock);
		#1;
		dout_ready = $urandom_range(0, 9) < 6;  // Ready in about 60% of cycles
	endtask

	// Biased toward zero, all ones and long zero runs for the counters
	function automatic logic [31:0] rand_operand();
		logic [31:0] r;
		r = $urandom;
		case ($urandom_range(0, 5))
			0:       return '0;
			1:       return '1;
			2:       return 32'b1 << r[4:0];
			3:       return r >> r[9:5];
			4:       return r << r[14:10];
			default: return r;
		endcase
	endfunction

	task automatic make_instruction(output logic [31:0] w, output bit supported);
		logic [31:0] r;
		logic [6:0]  opc;
		logic [6:0]  f7;
		logic [2:0]  f3;
		logic [4:0]  fld;
		int          kind;
		r = $urandom;
		fld = r[24:20];  // rs2 number or shift amount
		f7 = `BITMANIP_F7_BASE;
		f3 = 3'b001;
		supported = $urandom_range(0, 9) != 0;
		if (!supported) begin
			kind = int'($urandom_range(0, 2));
			opc = `BITMANIP_OPC_OP_IMM;
			case (kind)
				0: begin
					opc = r[6:0];
					if (opc == `BITMANIP_OPC_OP || opc == `BITMANIP_OPC_OP_IMM)
						opc[4] = 1'b0;  // Some other major opcode
				end
				1: begin
					opc = `BITMANIP_OPC_OP;
					{f7, f3} = {7'b0000001, r[14:12]};  // Multiply group
				end
				default: {f7, f3, fld} = {`BITMANIP_F7_ROT, 3'b001, 5'($urandom_range(3, 31))};
			endcase
		end else begin
			kind = int'($urandom_range(0, 18));
			opc = (kind < 12) ? `BITMANIP_OPC_OP : `BITMANIP_OPC_OP_IMM;
			case (kind)
				0:  {f7, f3} = {`BITMANIP_F7_NEG, 3'b111};     // ANDN
				1:  {f7, f3} = {`BITMANIP_F7_NEG, 3'b110};     // ORN
				2:  {f7, f3} = {`BITMANIP_F7_NEG, 3'b100};     // XNOR
				3:  {f7, f3} = {`BITMANIP_F7_MINMAX, 3'b100};  // MIN
				4:  {f7, f3} = {`BITMANIP_F7_MINMAX, 3'b101};  // MAX
				5:  {f7, f3} = {`BITMANIP_F7_MINMAX, 3'b110};  // MINU
				6:  {f7, f3} = {`BITMANIP_F7_MINMAX, 3'b111};  // MAXU
				7:  {f7, f3} = {`BITMANIP_F7_BASE, 3'b001};    // SLL
				8:  {f7, f3} = {`BITMANIP_F7_BASE, 3'b101};    // SRL
				9:  {f7, f3} = {`BITMANIP_F7_NEG, 3'b101};     // SRA
				10: {f7, f3} = {`BITMANIP_F7_ROT, 3'b001};     // ROL
				11: {f7, f3} = {`BITMANIP_F7_ROT, 3'b101};     // ROR
				12: {f7, f3} = {`BITMANIP_F7_BASE, 3'b001};    // SLLI
				13: {f7, f3} = {`BITMANIP_F7_BASE, 3'b101};    // SRLI
				14: {f7, f3} = {`BITMANIP_F7_NEG, 3'b101};     // SRAI
				15: {f7, f3} = {`BITMANIP_F7_ROT, 3'b101};     // RORI
				16: {f7, f3, fld} = {`BITMANIP_F7_ROT, 3'b001, 5'd0};  // CLZ
				17: {f7, f3, fld} = {`BITMANIP_F7_ROT, 3'b001, 5'd1};  // CTZ
				default: {f7, f3, fld} = {`BITMANIP_F7_ROT, 3'b001, 5'd2};  // PCNT
			endcase
		end
		w = {f7, fld, r[19:15], f3, r[11:7], opc};
	endtask

	// Unsupported words are offered for one cycle only
	task automatic send_instruction();
		logic [31:0] w;
		bit          supported;
		bit          taken;
		make_instruction(w, supported);
		din_valid = 1'b1;
		din_insn  = w;
		din_rs1   = rand_operand();
		din_rs2   = rand_operand();
		taken     = !supported;
		if (!supported)
			next_cycle();
		while (!taken) begin
			@(negedge clock);
			taken = din_ready;  // Inputs are stable until the next edge
			next_cycle();
		end
	endtask

	task automatic print_counts();
		$display("Checks done: %0d value errors, %0d other errors, %0d results outstanding",
			value_errors, other_errors, pending);
	endtask

	initial begin
		void'($urandom(32'hd870));
		reset      = 1'b1;
		din_valid  = 1'b0;
		din_rs1    = '0;
		din_rs2    = '0;
		// A supported word leaves only reset to hold din_ready low
		din_insn   = {`BITMANIP_F7_NEG, 10'd0, 3'b111, 5'd0, `BITMANIP_OPC_OP};
		dout_ready = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		reset    = 1'b0;
		din_insn = '0;
		repeat (3) next_cycle();
		for (int n = 0; n < NUM_INSNS; n++)
			send_instruction();
		din_valid = 1'b0;
		din_insn  = '0;
		while (pending != 0 || dout_valid)
			next_cycle();
		repeat (20) next_cycle();  // Any extra result shows up here
		print_counts();
		if (value_errors == 0 && other_errors == 0 && pending == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		print_counts();
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* tests/bitmanip_checker.sv */
// Result checker of the bit-manipulation core testbench.
// Watches both handshakes in the middle of each clock period, predicts every
// accepted instruction with its own model and compares in acceptance order.
`timescale 1ns/1ps
`include "bitmanip_config.svh"

module bitmanip_checker (
	input  logic        clock,
	input  logic        reset,
	input  logic        din_valid,
	input  logic        din_ready,
	input  logic        din_decoded,
	input  logic [31:0] din_rs1,
	input  logic [31:0] din_rs2,
	input  logic [31:0] din_insn,
	input  logic        dout_valid,
	input  logic        dout_ready,
	input  logic [31:0] dout_rd,
	output int          value_errors,
	output int          other_errors,
	output int          pending
);

	logic [31:0] expected_q[$];
	int          value_count = 0;
	int          other_count = 0;
	int          queue_size  = 0;
	logic        reset_seen  = 1'b0;
	logic        waiting     = 1'b0;  // Result offered but not taken
	logic [31:0] held_rd     = '0;

	assign value_errors = value_count;
	assign other_errors = other_count;
	assign pending      = queue_size;

	function automatic logic [31:0] leading_zeros(input logic [31:0] v);
		logic [31:0] n;
		n = 32'd32;
		for (int k = 0; k < 32; k++)
			if (v[k])
				n = 32'(31 - k);  // Highest set bit wins
		return n;
	endfunction

	function automatic logic [31:0] trailing_zeros(input logic [31:0] v);
		logic [31:0] n;
		n = 32'd32;
		for (int k = 31; k >= 0; k--)
			if (v[k])
				n = 32'(k);  // Lowest set bit wins
		return n;
	endfunction

	// Returns 0 for words outside the supported set
	function automatic bit model_exec(input logic [31:0] w, input logic [31:0] a,
			input logic [31:0] rs2, output logic [31:0] res);
		logic [31:0] b;
		logic [5:0]  sh;
		bit          ok;
		b = (w[6:0] == `BITMANIP_OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : rs2;
		sh = {1'b0, b[4:0]};
		ok = 1'b1;
		res = '0;
		case ({w[6:0], w[31:25], w[14:12]})
			{`BITMANIP_OPC_OP, `BITMANIP_F7_NEG, 3'b111}:    res = a & ~b;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_NEG, 3'b110}:    res = a | ~b;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_NEG, 3'b100}:    res = a ^ ~b;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_MINMAX, 3'b100}: res = ($signed(a) < $signed(b)) ? a : b;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_MINMAX, 3'b101}: res = ($signed(a) > $signed(b)) ? a : b;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_MINMAX, 3'b110}: res = (a < b) ? a : b;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_MINMAX, 3'b111}: res = (a > b) ? a : b;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_BASE, 3'b001},
			{`BITMANIP_OPC_OP_IMM, `BITMANIP_F7_BASE, 3'b001}: res = a << sh;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_BASE, 3'b101},
			{`BITMANIP_OPC_OP_IMM, `BITMANIP_F7_BASE, 3'b101}: res = a >> sh;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_NEG, 3'b101},
			{`BITMANIP_OPC_OP_IMM, `BITMANIP_F7_NEG, 3'b101}:  res = $signed(a) >>> sh;
			{`BITMANIP_OPC_OP, `BITMANIP_F7_ROT, 3'b001}: res = (a << sh) | (a >> (6'd32 - sh));
			{`BITMANIP_OPC_OP, `BITMANIP_F7_ROT, 3'b101},
			{`BITMANIP_OPC_OP_IMM, `BITMANIP_F7_ROT, 3'b101}:
				res = (a >> sh) | (a << (6'd32 - sh));
			{`BITMANIP_OPC_OP_IMM, `BITMANIP_F7_ROT, 3'b001}: begin
				case (w[24:20])  // Count select sits in the rs2 slot
					5'd0:    res = leading_zeros(a);
					5'd1:    res = trailing_zeros(a);
					5'd2:    res = 32'($countones(a));
					default: ok = 1'b0;
				endcase
			end
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

	always @(negedge clock) begin
		logic [31:0] predicted;
		logic [31:0] expected;
		bit          supported;
		supported = model_exec(din_insn, din_rs1, din_rs2, predicted);
		if (reset || reset_seen) begin  // Reset and the first cycle after it
			if (dout_valid !== 1'b0) begin
				$display("ERR dout_valid at %0t: expected %h, got %h", $time, 1'b0, dout_valid);
				value_count++;
			end
			if (din_ready !== 1'b0) begin
				$display("ERR din_ready at %0t: expected %h, got %h", $time, 1'b0, din_ready);
				value_count++;
			end
		end
		reset_seen = reset;
		if (reset) begin
			waiting = 1'b0;
		end else begin
			if (din_decoded !== supported) begin
				$display("ERR din_decoded for insn %h: expected %h, got %h",
					din_insn, supported, din_decoded);
				value_count++;
			end
			if (!supported && din_valid && din_ready !== 1'b0) begin
				$display("ERR din_ready for insn %h: expected %h, got %h",
					din_insn, 1'b0, din_ready);
				value_count++;
			end
			if (supported && din_valid && din_ready === 1'b1)
				expected_q.push_back(predicted);
			if (waiting) begin
				if (dout_valid !== 1'b1) begin
					$display("dout_valid dropped at %0t before the result was taken", $time);
					other_count++;
				end else if (dout_rd !== held_rd) begin
					$display("ERR dout_rd while stalled: expected %h, got %h", held_rd, dout_rd);
					value_count++;
				end
			end
			if (dout_valid === 1'b1 && dout_ready) begin
				if (expected_q.size() == 0) begin
					$display("Result %h at %0t has no accepted instruction behind it",
						dout_rd, $time);
					other_count++;
				end else begin
					expected = expected_q.pop_front();
					if (dout_rd !== expected) begin
						$display("ERR dout_rd: expected %h, got %h", expected, dout_rd);
						value_count++;
					end
				end
			end
			waiting = dout_valid === 1'b1 && !dout_ready;
			held_rd = dout_rd;
		end
		queue_size = expected_q.size();
	end

endmodule

/* verilog/bitmanip_core.sv */
// Top level of the bit-manipulation execution core.
// The host offers rs1, rs2 and an instruction under valid/ready; one
// instruction is in flight at a time and its result is held on dout_rd
// until the host takes it with dout_ready.
`timescale 1ns/1ps
`include "bitmanip_config.svh"

module bitmanip_core (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      din_valid,
	output logic                      din_ready,
	output logic                      din_decoded,   // Instruction is supported
	input  logic [`BITMANIP_XLEN-1:0] din_rs1,
	input  logic [`BITMANIP_XLEN-1:0] din_rs2,
	input  logic [31:0]               din_insn,
	output logic                      dout_valid,
	input  logic                      dout_ready,
	output logic [`BITMANIP_XLEN-1:0] dout_rd
);

	bitmanip_pkg::insn_word_u   insn;
	bitmanip_pkg::unit_sel_t    dec_sel;
	bitmanip_pkg::unit_sel_t    in_sel;     // Pending unit start
	bitmanip_pkg::op_req_t      in_req;
	bitmanip_pkg::unit_result_t logic_res;
	bitmanip_pkg::unit_result_t shift_res;
	bitmanip_pkg::unit_result_t count_res;

	logic [`BITMANIP_XLEN-1:0] op2;
	logic                      logic_ready;
	logic                      shift_ready;
	logic                      count_ready;
	logic                      out_ready;
	logic                      out_any_valid;
	logic                      output_valid;
	logic [`BITMANIP_XLEN-1:0] output_value;
	logic                      busy;
	logic                      busy_reg;

	assign insn = din_insn;

	// Opcode bit 5 separates OP from OP-IMM
	assign op2 = insn.r.opcode[5] ? din_rs2
		: {{(`BITMANIP_XLEN - 12){insn.i.imm[11]}}, insn.i.imm};

	bitmanip_decoder i_decoder (
		.insn (insn),
		.sel  (dec_sel)
	);

	assign din_decoded = |dec_sel;
	assign din_ready   = !reset && !busy && din_decoded;

	always_ff @(posedge clock) begin
		if (logic_ready) in_sel.logic_op <= 1'b0;  // Start taken by the unit
		if (shift_ready) in_sel.shift_op <= 1'b0;
		if (count_ready) in_sel.count_op <= 1'b0;
		if (din_valid && din_ready) begin
			in_sel      <= dec_sel;
			in_req.rs1  <= din_rs1;
			in_req.op2  <= op2;
			in_req.insn <= insn;
		end
		if (reset)
			in_sel <= '0;
	end

	bitmanip_logic_unit i_logic_unit (
		.clock     (clock),
		.reset     (reset),
		.start     (in_sel.logic_op),
		.req       (in_req),
		.ready     (logic_ready),
		.out_ready (out_ready),
		.result    (logic_res)
	);

	bitmanip_shift_unit i_shift_unit (
		.clock     (clock),
		.reset     (reset),
		.start     (in_sel.shift_op),
		.req       (in_req),
		.ready     (shift_ready),
		.out_ready (out_ready),
		.result    (shift_res)
	);

	bitmanip_count_unit i_count_unit (
		.clock     (clock),
		.reset     (reset),
		.start     (in_sel.count_op),
		.req       (in_req),
		.ready     (count_ready),
		.out_ready (out_ready),
		.result    (count_res)
	);

	assign out_ready     = !output_valid || dout_ready;
	assign out_any_valid = logic_res.valid || shift_res.valid || count_res.valid;

	always_ff @(posedge clock) begin
		if (output_valid && dout_ready)
			output_valid <= 1'b0;
		if (out_ready && out_any_valid) begin
			output_valid <= 1'b1;
			if (logic_res.valid)
				output_value <= logic_res.value;
			else if (shift_res.valid)
				output_value <= shift_res.value;
			else
				output_value <= count_res.value;
		end
		if (reset)
			output_valid <= 1'b0;
	end

	assign dout_valid = output_valid;
	assign dout_rd    = output_value;

	// Busy from acceptance until the unit result moves to the output
	always_comb begin
		busy = busy_reg || (|in_sel);
		if (out_ready && out_any_valid)
			busy = 1'b0;
	end

	always_ff @(posedge clock) begin
		if (reset)
			busy_reg <= 1'b0;
		else
			busy_reg <= busy;
	end

	one_unit_result: assert property (@(posedge clock) disable iff (reset)
		$onehot0({logic_res.valid, shift_res.valid, count_res.valid}))
		else $error("more than one unit holds a result");

	hold_under_backpressure: assert property (@(posedge clock) disable iff (reset)
		dout_valid && !dout_ready |=> dout_valid && $stable(dout_rd))
		else $error("dout_rd changed while waiting for dout_ready");

endmodule

/* verilog/bitmanip_count_unit.sv */
// Iterative bit counter for CLZ, CTZ and PCNT.
// Walks the operand a few bits per cycle from the top; CTZ counts on the
// bit-reversed operand. Ready stays low until the count is done.
`timescale 1ns/1ps
`include "bitmanip_config.svh"

module bitmanip_count_unit (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start,
	input  bitmanip_pkg::op_req_t      req,
	output logic                       ready,
	input  logic                       out_ready,
	output bitmanip_pkg::unit_result_t result
);

	localparam int STEPS = `BITMANIP_XLEN / `BITMANIP_COUNT_BITS;

	logic                            counting;
	logic                            pcnt_mode;
	logic [$clog2(STEPS)-1:0]        step;
	logic [`BITMANIP_XLEN-1:0]       data;
	logic [`BITMANIP_XLEN-1:0]       rev;
	logic [`BITMANIP_CNT_WIDTH-1:0]  cnt;
	logic [`BITMANIP_CNT_WIDTH-1:0]  cnt_next;
	logic [`BITMANIP_COUNT_BITS-1:0] nibble;
	logic                            done;

	function automatic logic [`BITMANIP_CNT_WIDTH-1:0] lead_zeros(
		input logic [`BITMANIP_COUNT_BITS-1:0] bits);
		logic [`BITMANIP_CNT_WIDTH-1:0] n;
		logic                           found;
		n = '0;
		found = 1'b0;
		for (int k = `BITMANIP_COUNT_BITS - 1; k >= 0; k--) begin
			if (bits[k])
				found = 1'b1;
			else if (!found)
				n = n + 1'b1;
		end
		return n;
	endfunction

	function automatic logic [`BITMANIP_CNT_WIDTH-1:0] ones(
		input logic [`BITMANIP_COUNT_BITS-1:0] bits);
		logic [`BITMANIP_CNT_WIDTH-1:0] n;
		n = '0;
		for (int k = 0; k < `BITMANIP_COUNT_BITS; k++)
			n = n + bits[k];
		return n;
	endfunction

	assign rev    = {<<{req.rs1}};
	assign nibble = data[`BITMANIP_XLEN-1 -: `BITMANIP_COUNT_BITS];
	assign ready  = !counting && (!result.valid || out_ready);

	always_comb begin
		if (pcnt_mode) begin
			cnt_next = cnt + ones(nibble);
			done = (data << `BITMANIP_COUNT_BITS) == '0;  // No ones left
		end else begin
			cnt_next = cnt + lead_zeros(nibble);
			done = nibble != '0;  // First one found
		end
		if (step == $clog2(STEPS)'(STEPS - 1))
			done = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (result.valid && out_ready)
			result.valid <= 1'b0;
		if (counting) begin
			data <= data << `BITMANIP_COUNT_BITS;
			cnt  <= cnt_next;
			step <= step + 1'b1;
			if (done) begin
				counting     <= 1'b0;
				result.valid <= 1'b1;
				result.value <= {{(`BITMANIP_XLEN - `BITMANIP_CNT_WIDTH){1'b0}}, cnt_next};
			end
		end else if (start && ready) begin
			counting  <= 1'b1;
			pcnt_mode <= req.insn.r.rs2[1];                  // 2 is PCNT
			data      <= req.insn.r.rs2[0] ? rev : req.rs1;  // 1 is CTZ
			cnt       <= '0;
			step      <= '0;
		end
		if (reset) begin
			counting     <= 1'b0;
			result.valid <= 1'b0;
		end
	end

	// The core's busy arbiter keeps a second start away during a count
	no_start_while_counting: assert property (
		@(posedge clock) disable iff (reset) start |-> !counting)
		else $error("count unit got a start while still counting");

endmodule

/* verilog/bitmanip_shift_unit.sv */
// Shift and rotate unit.
// Handles SLL, SRL, SRA, ROL, ROR and their immediate forms in one cycle;
// the shift amount is always taken from the low bits of operand 2.
`timescale 1ns/1ps
`include "bitmanip_config.svh"

module bitmanip_shift_unit (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start,
	input  bitmanip_pkg::op_req_t      req,
	output logic                       ready,
	input  logic                       out_ready,
	output bitmanip_pkg::unit_result_t result
);

	logic [`BITMANIP_XLEN-1:0]         a;
	logic [$clog2(`BITMANIP_XLEN)-1:0] amt;
	logic [2*`BITMANIP_XLEN-1:0]       rot_l;
	logic [2*`BITMANIP_XLEN-1:0]       rot_r;
	logic [`BITMANIP_XLEN-1:0]         value;

	assign a     = req.rs1;
	assign amt   = req.op2[$clog2(`BITMANIP_XLEN)-1:0];
	assign rot_l = {a, a} << amt;  // Upper half is the left rotate
	assign rot_r = {a, a} >> amt;  // Lower half is the right rotate
	assign ready = !result.valid || out_ready;

	// Immediate forms carry the same group code in imm[11:5]
	always_comb begin
		if (req.insn.r.funct7 == `BITMANIP_F7_ROT)
			value = req.insn.r.funct3[2] ? rot_r[`BITMANIP_XLEN-1:0]
				: rot_l[2*`BITMANIP_XLEN-1 -: `BITMANIP_XLEN];
		else if (!req.insn.r.funct3[2])
			value = a << amt;
		else if (req.insn.r.funct7 == `BITMANIP_F7_NEG)
			value = $signed(a) >>> amt;  // SRA, SRAI
		else
			value = a >> amt;
	end

	always_ff @(posedge clock) begin
		if (result.valid && out_ready)
			result.valid <= 1'b0;
		if (start && ready) begin
			result.valid <= 1'b1;
			result.value <= value;
		end
		if (reset)
			result.valid <= 1'b0;
	end

endmodule

/* verilog/bitmanip_logic_unit.sv */
// Negated-logic and min/max unit.
// Computes ANDN, ORN, XNOR, MIN, MAX, MINU and MAXU in one cycle and holds
// the result until the output stage takes it.
`timescale 1ns/1ps
`include "bitmanip_config.svh"

module bitmanip_logic_unit (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start,
	input  bitmanip_pkg::op_req_t      req,
	output logic                       ready,
	input  logic                       out_ready,
	output bitmanip_pkg::unit_result_t result
);

	logic [`BITMANIP_XLEN-1:0] a;
	logic [`BITMANIP_XLEN-1:0] b;
	logic [`BITMANIP_XLEN-1:0] value;
	logic                      lt;

	assign a = req.rs1;
	assign b = req.op2;
	assign ready = !result.valid || out_ready;

	always_comb begin
		// funct3[1] set for the unsigned forms
		lt = req.insn.r.funct3[1] ? (a < b) : ($signed(a) < $signed(b));
		if (req.insn.r.funct7 == `BITMANIP_F7_MINMAX) begin
			value = (lt ^ req.insn.r.funct3[0]) ? a : b;  // funct3[0] picks max
		end else begin
			case (req.insn.r.funct3[1:0])
				2'b11:   value = a & ~b;  // ANDN
				2'b10:   value = a | ~b;  // ORN
				default: value = a ^ ~b;  // XNOR
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (result.valid && out_ready)
			result.valid <= 1'b0;
		if (start && ready) begin
			result.valid <= 1'b1;
			result.value <= value;
		end
		if (reset)
			result.valid <= 1'b0;
	end

endmodule

/* verilog/bitmanip_decoder.sv */
// Instruction decoder of the bit-manipulation core.
// Maps an instruction word onto the functional unit that executes it;
// an all-zero select means the core does not support the word.
`timescale 1ns/1ps
`include "bitmanip_config.svh"

module bitmanip_decoder (
	input  bitmanip_pkg::insn_word_u insn,
	output bitmanip_pkg::unit_sel_t  sel
);

	always_comb begin
		sel = '0;
		if (insn.r.opcode == `BITMANIP_OPC_OP) begin
			case (insn.r.funct7)
				`BITMANIP_F7_NEG: begin
					// ANDN, ORN, XNOR
					sel.logic_op = insn.r.funct3 inside {3'b111, 3'b110, 3'b100};
					sel.shift_op = insn.r.funct3 == 3'b101;  // SRA
				end
				`BITMANIP_F7_MINMAX: begin
					sel.logic_op = insn.r.funct3[2];  // MIN, MAX, MINU, MAXU
				end
				`BITMANIP_F7_BASE, `BITMANIP_F7_ROT: begin
					// SLL, SRL, ROL, ROR
					sel.shift_op = insn.r.funct3 inside {3'b001, 3'b101};
				end
				default: begin
					sel = '0;
				end
			endcase
		end else if (insn.i.opcode == `BITMANIP_OPC_OP_IMM) begin
			case (insn.i.imm[11:5])
				`BITMANIP_F7_BASE: begin
					sel.shift_op = insn.i.funct3 inside {3'b001, 3'b101};  // SLLI, SRLI
				end
				`BITMANIP_F7_NEG: begin
					sel.shift_op = insn.i.funct3 == 3'b101;  // SRAI
				end
				`BITMANIP_F7_ROT: begin
					sel.shift_op = insn.i.funct3 == 3'b101;  // RORI
					// CLZ, CTZ, PCNT live in the rs2 slot
					sel.count_op = insn.i.funct3 == 3'b001 &&
						insn.r.rs2 inside {5'd0, 5'd1, 5'd2};
				end
				default: begin
					sel = '0;
				end
			endcase
		end
	end

	// The core holds exactly one unit start per instruction
	always_comb begin
		assert ($onehot0(sel))
			else $error("decoder selects more than one unit: %b", sel);
	end

endmodule

/* verilog/bitmanip_pkg.sv */
// Shared types of the bit-manipulation core: the instruction word views,
// the registered request, the unit select and the unit result.
`include "bitmanip_config.svh"

package bitmanip_pkg;

	// R-type view of the instruction word
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;     // Also selects the count operation
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fields_t;

	// I-type view of the instruction word
	typedef struct packed {
		logic [11:0] imm;    // Upper 7 bits pick the shift type
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} insn_word_u;

	typedef struct packed {
		logic [`BITMANIP_XLEN-1:0] rs1;
		logic [`BITMANIP_XLEN-1:0] op2;  // Register or sign-extended immediate
		insn_word_u                insn;
	} op_req_t;

	// One-hot functional unit select
	typedef struct packed {
		logic logic_op;
		logic shift_op;
		logic count_op;
	} unit_sel_t;

	typedef struct packed {
		logic                      valid;
		logic [`BITMANIP_XLEN-1:0] value;
	} unit_result_t;

endpackage

/* verilog/bitmanip_config.svh */
// Widths and instruction encodings of the bit-manipulation core.
// Included by the package, the RTL modules and the testbench.
`ifndef BITMANIP_CONFIG_SVH
`define BITMANIP_CONFIG_SVH

`define BITMANIP_XLEN       32  // Operand width
`define BITMANIP_CNT_WIDTH  6   // Count result field up to 32

// Major opcodes
`define BITMANIP_OPC_OP     7'b0110011  // Register-register
`define BITMANIP_OPC_OP_IMM 7'b0010011  // Register-immediate

// Funct7 groups and the upper immediate bits of the I-type forms
`define BITMANIP_F7_BASE    7'b0000000
`define BITMANIP_F7_NEG     7'b0100000
`define BITMANIP_F7_MINMAX  7'b0000101
`define BITMANIP_F7_ROT     7'b0110000

`define BITMANIP_COUNT_BITS 4  // Bits examined per cycle by the count unit

`endif
